// ==== logic/uart_rx_params.svh ====
`ifndef UART_RX_PARAMS_SVH
`define UART_RX_PARAMS_SVH

// Frame format of the serial line
`define UART_DATA_BITS 8 // One data word per frame, sent MSB first
`define UART_STOP_BITS 2 // Both stop bits are checked for the frame flag

// Start bit, data bits, even parity bit and stop bits
`define UART_FRAME_BITS (1 + `UART_DATA_BITS + 1 + `UART_STOP_BITS)

// Bit timing
`define UART_OVERSAMPLE 16 // Ticks per bit
// System clock over 16 times the baud rate, kept small so a bit is 64 cycles in simulation
`define UART_CLKS_PER_TICK 4

// Default number of words buffered between the receiver and the consumer
`define UART_FIFO_DEPTH 4

`endif

// ==== logic/uart_frame_pkg.sv ====
`include "uart_rx_params.svh"

// Vector types for everything that describes a received frame
package uart_frame_pkg;

    // One received data word
    typedef logic [`UART_DATA_BITS-1:0] rx_data_t;

    // Raw frame as shifted in, the start bit ends up in the top bit
    // Below it sit the data bits MSB first, then parity, then the stop bits
    typedef logic [`UART_FRAME_BITS-1:0] rx_frame_t;

    // Error flags that travel with each word
    // Bit 0 is break, bit 1 parity, bit 2 frame and bit 3 overrun
    typedef logic [3:0] rx_err_t;

    // Number of frame bits taken so far
    typedef logic [3:0] rx_bitcnt_t; // Has to reach UART_FRAME_BITS without wrapping

endpackage

// ==== logic/uart_ctrl_pkg.sv ====
// Types for the receive control path
package uart_ctrl_pkg;

    // Receiver sequence, one frame runs through every state once
    typedef enum logic [2:0] {
        IDLE,    // Waiting for the falling edge of a start bit
        RECEIVE, // Timer runs and the shifter collects bits
        CHECK,   // Checker registers the word and flags
        STORE,   // Word is pushed into the FIFO
        RECOVER  // Timer and shifter are cleared
    } rx_state_t;

    // Position of the current tick within one bit
    typedef logic [3:0] os_count_t;

endpackage

// ==== logic/rx_baud_timer.sv ====
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module rx_baud_timer (
    input  logic Clk,
    input  logic Rst,
    input  logic timer_en,  // Both counters run only while this is high
    output logic sample_stb // One cycle pulse in the middle of each bit
);
    import uart_ctrl_pkg::*;

    localparam int DIV_W = $clog2(`UART_CLKS_PER_TICK + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_CLKS_PER_TICK - 1);
    localparam os_count_t OS_LAST = os_count_t'(`UART_OVERSAMPLE - 1);
    // Tick number 8 of 16 when counting from one is count value 7
    localparam os_count_t OS_MID = os_count_t'(`UART_OVERSAMPLE / 2 - 1);

    logic [DIV_W-1:0] div_cnt; // Clock cycles within the current tick
    os_count_t        os_cnt;  // Ticks within the current bit
    logic             tick;

    // The divider restarts from zero on every enable, so the first tick
    // lands a fixed number of cycles after the start edge was seen
    assign tick = timer_en && (div_cnt == DIV_LAST);

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            div_cnt <= '0;
        end else if (!timer_en || tick) begin
            div_cnt <= '0; // Held cleared while disabled
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Tick counter wraps once per bit
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            os_cnt <= '0;
        end else if (!timer_en) begin
            os_cnt <= '0;
        end else if (tick) begin
            os_cnt <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
        end
    end

    // First strobe is half a bit after enable, which is the middle of the start bit
    assign sample_stb = tick && (os_cnt == OS_MID);

endmodule

// ==== logic/rx_control_fsm.sv ====
`timescale 1ns/1ps

module rx_control_fsm (
    input  logic Clk,
    input  logic Rst,
    input  logic rxd,        // Serial line, idles high
    input  logic frame_done, // All frame bits have been sampled
    input  logic fifo_full,
    output logic timer_en,   // Runs the timer and the shifter
    output logic check_en,   // One cycle pulse to the checker
    output logic push,       // One cycle pulse to the FIFO
    output logic rts         // Sender may start a frame
);
    import uart_ctrl_pkg::*;

    rx_state_t state;
    rx_state_t state_nxt;

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // A low line in idle is taken as the start edge
                if (!rxd) begin
                    state_nxt = RECEIVE;
                end
            end
            RECEIVE: begin
                if (frame_done) begin
                    state_nxt = CHECK; // Shifter holds the frame from here on
                end
            end
            CHECK:   state_nxt = STORE;   // Checker registers during this cycle
            STORE:   state_nxt = RECOVER; // Checker outputs are valid for the push
            RECOVER: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Timer stays enabled up to the push so that the frame register holds still
    // It drops in RECOVER, which clears tick and bit counts before IDLE
    assign timer_en = (state == RECEIVE) || (state == CHECK) || (state == STORE);

    assign check_en = (state == CHECK);
    assign push     = (state == STORE);

    // Busy or out of buffer space means the sender has to wait
    assign rts = (state == IDLE) && !fifo_full;

endmodule

// ==== logic/rx_frame_shifter.sv ====
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module rx_frame_shifter (
    input  logic                      Clk,
    input  logic                      Rst,
    input  logic                      timer_en,   // Low clears the frame and the count
    input  logic                      sample_stb, // Mid-bit strobe from the timer
    input  logic                      rxd,
    output uart_frame_pkg::rx_frame_t frame,
    output logic                      frame_done  // Stays high until timer_en drops
);
    import uart_frame_pkg::*;

    localparam rx_bitcnt_t BITS_LAST = rx_bitcnt_t'(`UART_FRAME_BITS);

    rx_bitcnt_t bit_cnt; // Bits taken in the current frame

    // Each new bit enters at the bottom
    // After a full frame the first bit received sits in the top position
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            frame   <= '0;
            bit_cnt <= '0;
        end else if (!timer_en) begin
            frame   <= '0;
            bit_cnt <= '0;
        end else if (sample_stb && !frame_done) begin
            frame   <= {frame[`UART_FRAME_BITS-2:0], rxd};
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Strobes that arrive after the last stop bit leave the frame untouched
    assign frame_done = (bit_cnt == BITS_LAST);

endmodule

// ==== logic/rx_frame_check.sv ====
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module rx_frame_check (
    input  logic                      Clk,
    input  logic                      Rst,
    input  logic                      check_en, // One cycle pulse while the frame is held
    input  uart_frame_pkg::rx_frame_t frame,
    output uart_frame_pkg::rx_data_t  data_word,
    output uart_frame_pkg::rx_err_t   err_flags
);
    import uart_frame_pkg::*;

    localparam int STOP = `UART_STOP_BITS;

    rx_data_t   data_bits;
    logic       parity_bit;
    logic [2:0] flags_q;   // Frame, parity and break from top to bottom

    // Data sits just below the start bit, parity just above the stop bits
    assign data_bits  = frame[`UART_FRAME_BITS-2 -: `UART_DATA_BITS];
    assign parity_bit = frame[STOP];

    always_ff @(posedge Clk) begin
        if (check_en) begin
            data_word <= data_bits;
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            flags_q <= '0;
        end else if (check_en) begin
            flags_q[0] <= (frame == '0);                  // Line held low for the whole frame
            flags_q[1] <= (parity_bit != ^data_bits);     // Even parity over data and parity bit
            flags_q[2] <= (frame[STOP-1:0] != {STOP{1'b1}}); // Some stop bit was low
        end
    end

    // Overrun is known only to the FIFO, which sets it when the word is stored
    assign err_flags = {1'b0, flags_q};

endmodule

// ==== logic/rx_word_fifo.sv ====
`timescale 1ns/1ps
`include "uart_rx_params.svh"

// Depth must be a power of two and at least two
module rx_word_fifo #(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  logic                     Clk,
    input  logic                     Rst,
    input  logic                     push,
    input  uart_frame_pkg::rx_data_t data_word,
    input  uart_frame_pkg::rx_err_t  err_flags,
    output logic                     full,
    output logic                     out_valid,
    input  logic                     out_ready,
    output uart_frame_pkg::rx_data_t out_data,
    output uart_frame_pkg::rx_err_t  out_err
);
    import uart_frame_pkg::*;

    localparam int AW = $clog2(DEPTH);

    rx_data_t   data_mem [DEPTH];
    rx_err_t    err_mem  [DEPTH];
    logic [AW:0] wr_ptr;  // Top bit flips on every wrap
    logic [AW:0] rd_ptr;
    logic       overrun; // A word was dropped since the last store
    logic       do_push;
    logic       do_pop;

    // Same index with different wrap bits means the writer is a full lap ahead
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign out_valid = (wr_ptr != rd_ptr);
    assign do_push   = push && !full;
    assign do_pop    = out_valid && out_ready;

    // Head entry cannot be overwritten while valid, so the output holds until taken
    assign out_data = data_mem[rd_ptr[AW-1:0]];
    assign out_err  = err_mem[rd_ptr[AW-1:0]];

    always_ff @(posedge Clk) begin
        if (do_push) begin
            data_mem[wr_ptr[AW-1:0]] <= data_word;
            err_mem[wr_ptr[AW-1:0]]  <= {err_flags[3] | overrun, err_flags[2:0]};
        end
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && full) begin
                overrun <= 1'b1; // Remembered until the next word goes in
            end else if (do_push) begin
                overrun <= 1'b0; // Flag now travels with the stored word
            end
        end
    end

endmodule

// ==== logic/uart_rx_top.sv ====
`timescale 1ns/1ps
`include "uart_rx_params.svh"

// The line is expected to arrive already synchronized to Clk
module uart_rx_top (
    input  logic                     Clk,
    input  logic                     Rst,
    input  logic                     rxd,
    output logic                     rts,
    output logic                     out_valid,
    input  logic                     out_ready,
    output uart_frame_pkg::rx_data_t out_data,
    output uart_frame_pkg::rx_err_t  out_err
);
    import uart_frame_pkg::*;

    logic      timer_en;
    logic      sample_stb;
    logic      frame_done;
    rx_frame_t frame;
    logic      check_en;
    logic      push;
    logic      fifo_full;
    rx_data_t  data_word;
    rx_err_t   err_flags;

    rx_control_fsm fsm_i (
        .Clk        (Clk),
        .Rst        (Rst),
        .rxd        (rxd),
        .frame_done (frame_done),
        .fifo_full  (fifo_full),
        .timer_en   (timer_en),
        .check_en   (check_en),
        .push       (push),
        .rts        (rts)
    );

    rx_baud_timer timer_i (
        .Clk        (Clk),
        .Rst        (Rst),
        .timer_en   (timer_en),
        .sample_stb (sample_stb)
    );

    rx_frame_shifter shifter_i (
        .Clk        (Clk),
        .Rst        (Rst),
        .timer_en   (timer_en),
        .sample_stb (sample_stb),
        .rxd        (rxd),
        .frame      (frame),
        .frame_done (frame_done)
    );

    rx_frame_check check_i (
        .Clk       (Clk),
        .Rst       (Rst),
        .check_en  (check_en),
        .frame     (frame),
        .data_word (data_word),
        .err_flags (err_flags)
    );

    rx_word_fifo #(
        .DEPTH (`UART_FIFO_DEPTH)
    ) fifo_i (
        .Clk       (Clk),
        .Rst       (Rst),
        .push      (push),
        .data_word (data_word),
        .err_flags (err_flags),
        .full      (fifo_full),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_err   (out_err)
    );

endmodule

// ==== bench/uart_rx_assert.sv ====
`timescale 1ns/1ps

module uart_rx_assert (
    input logic                     Clk,
    input logic                     Rst,
    input logic                     rxd,
    input logic                     rts,
    input logic                     timer_en,
    input logic                     sample_stb,
    input logic                     frame_done,
    input logic                     check_en,
    input logic                     push,
    input logic                     out_valid,
    input logic                     out_ready,
    input uart_frame_pkg::rx_data_t out_data,
    input uart_frame_pkg::rx_err_t  out_err
);

    // A word offered and not taken stays on the output unchanged
    a_out_hold: assert property (@(posedge Clk) disable iff (Rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_err)))
        else $error("out_valid or its payload changed before the word was accepted");

    // A start edge seen while ready makes the receiver busy, so the sender is held off
    a_rts_busy: assert property (@(posedge Clk) disable iff (Rst)
        (rts && !rxd) |=> !rts)
        else $error("rts stayed high after a start bit arrived");

    // Control outputs are quiet in reset and on the first cycle after it
    a_reset_quiet: assert property (@(posedge Clk)
        (Rst || $fell(Rst)) |-> (!timer_en && !sample_stb && !frame_done && !check_en
                                 && !push && !out_valid && rts))
        else $error("A control output was active in or right after reset");

endmodule

bind uart_rx_top uart_rx_assert assert_i (
    .Clk        (Clk),
    .Rst        (Rst),
    .rxd        (rxd),
    .rts        (rts),
    .timer_en   (timer_en),
    .sample_stb (sample_stb),
    .frame_done (frame_done),
    .check_en   (check_en),
    .push       (push),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_err    (out_err)
);

// ==== bench/tb_uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_rx_params.svh"

module tb_uart_rx;
    import uart_frame_pkg::*;

    localparam int BIT_CYCLES = `UART_OVERSAMPLE * `UART_CLKS_PER_TICK; // 64 cycles per bit
    // Last stop bit is released early so a low stop bit is not taken as the next start edge
    localparam int LAST_HOLD      = 36;
    localparam int N_FRAMES       = 48 + `UART_FIFO_DEPTH; // Sum of the frames sent below
    localparam int TIMEOUT_CYCLES = N_FRAMES * 800 + 5000;
    // A pending word leaves the DUT well within one frame time once out_ready is high
    localparam int DRAIN_LIMIT    = BIT_CYCLES * `UART_FRAME_BITS;

    logic     Clk;
    logic     Rst;
    logic     rxd;
    logic     rts;
    logic     out_valid;
    logic     out_ready;
    rx_data_t out_data;
    rx_err_t  out_err;

    logic [31:0]                lfsr;
    logic                       ready_random;    // out_ready follows the LFSR when set
    logic                       overrun_pending; // A frame was dropped since the last stored one
    logic [`UART_DATA_BITS+3:0] exp_q [$];       // Expected {err, data} in arrival order

    uart_rx_top dut_i (
        .Clk       (Clk),
        .Rst       (Rst),
        .rxd       (rxd),
        .rts       (rts),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_err   (out_err)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk; // 4 ns period
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic next_rand_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic rx_data_t rand_word();
        rx_data_t w;
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            w[i] = next_rand_bit();
        end
        return w;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // All driving happens 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge Clk);
        #1;
        if (ready_random) begin
            out_ready = next_rand_bit() | next_rand_bit(); // High about three cycles in four
        end
    endtask

    // Serializes one frame MSB first and records what the receiver has to deliver
    task automatic send_frame(input rx_data_t data, input logic bad_parity,
                              input logic bad_stop, input logic brk, input logic store);
        logic [`UART_FRAME_BITS-1:0] bits;
        rx_err_t                     err;
        rx_data_t                    exp_data;
        bits = {1'b0, data, (^data) ^ bad_parity, ~bad_stop, {(`UART_STOP_BITS-1){1'b1}}};
        if (brk) begin
            bits = '0; // Line held low through every bit
        end
        exp_data = brk ? '0 : data; // A break frame carries only zero data bits
        err[0] = brk;
        err[1] = bad_parity && !brk; // All zero gives even parity
        err[2] = bad_stop || brk;
        err[3] = overrun_pending;
        if (store) begin
            exp_q.push_back({err, exp_data});
            overrun_pending = 1'b0;
        end else begin
            overrun_pending = 1'b1; // FIFO is full, so the next stored word carries overrun
        end
        for (int i = `UART_FRAME_BITS - 1; i >= 0; i--) begin
            rxd = bits[i];
            if (i == 0) begin
                repeat (LAST_HOLD) wait_cycle(); // Past the mid-bit sample
                rxd = 1'b1;
                repeat (BIT_CYCLES - LAST_HOLD) wait_cycle();
            end else begin
                repeat (BIT_CYCLES) wait_cycle();
            end
        end
    endtask

    // Every expected word has to leave the DUT in bounded time
    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                stop_on_error("Some received words never came out of the DUT");
            end else begin
                wait_cycle();
                waited++;
            end
        end
        repeat (4) wait_cycle();
    endtask

    // Scoreboard compares every accepted word with the oldest expected one
    always @(posedge Clk) begin : scoreboard
        logic [`UART_DATA_BITS+3:0] expected;
        if (!Rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                stop_on_error("An output word was accepted although no frame was pending");
            end else begin
                expected = exp_q.pop_front();
                assert ({out_err, out_data} == expected)
                    else stop_on_error($sformatf(
                        "FAIL at time %0t: got err %b data %h, expected err %b data %h",
                        $time, out_err, out_data, expected[`UART_DATA_BITS+3 -: 4],
                        expected[`UART_DATA_BITS-1:0]));
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge Clk);
        stop_on_error("Timeout: the test did not finish within the expected number of cycles");
    end

    initial begin
        Rst             = 1'b1;
        rxd             = 1'b1; // Line idles high
        out_ready       = 1'b1;
        ready_random    = 1'b0;
        overrun_pending = 1'b0;
        lfsr            = 32'h0c54_8b68;
        repeat (5) @(posedge Clk);
        #1 Rst = 1'b0;
        repeat (4) wait_cycle();

        repeat (20) send_frame(rand_word(), 1'b0, 1'b0, 1'b0, 1'b1); // Clean words
        repeat (3) send_frame(rand_word(), 1'b1, 1'b0, 1'b0, 1'b1);  // Wrong parity bit
        repeat (2) send_frame(rand_word(), 1'b0, 1'b1, 1'b0, 1'b1);  // First stop bit low
        send_frame('0, 1'b0, 1'b0, 1'b1, 1'b1);                      // Break
        drain_outputs();

        // Back-pressure fills the FIFO, then one more frame is dropped
        out_ready = 1'b0;
        repeat (`UART_FIFO_DEPTH) send_frame(rand_word(), 1'b0, 1'b0, 1'b0, 1'b1);
        wait_cycle();
        assert (!rts && out_valid)
            else stop_on_error("rts stayed high or out_valid was low with the FIFO full");
        send_frame(rand_word(), 1'b0, 1'b0, 1'b0, 1'b0);
        out_ready = 1'b1;
        drain_outputs();
        send_frame(rand_word(), 1'b0, 1'b0, 1'b0, 1'b1); // Picks up the overrun flag
        drain_outputs();

        ready_random = 1'b1; // Stream with random gaps on out_ready
        repeat (20) send_frame(rand_word(), 1'b0, 1'b0, 1'b0, 1'b1);
        ready_random = 1'b0;
        out_ready    = 1'b1;
        drain_outputs();

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/uart_frame_pkg.sv
logic/uart_ctrl_pkg.sv
logic/rx_baud_timer.sv
logic/rx_control_fsm.sv
logic/rx_frame_shifter.sv
logic/rx_frame_check.sv
logic/rx_word_fifo.sv
logic/uart_rx_top.sv
bench/uart_rx_assert.sv
bench/tb_uart_rx.sv

// ==== Makefile ====
TOOL      ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/1ps
TOP       ?= tb_uart_rx
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
